//--- sim.f
source/pipelinePkg.sv
source/enabledShiftRegister.sv
source/delayPipe.sv
source/botValidTracker.sv
source/botIndexCounter.sv
source/topLoadController.sv
source/scorePipeline.sv
source/pipelineTop.sv
verification/pipelineTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module pipelineTb --Mdir obj_dir -o pipelineSim

./obj_dir/pipelineSim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- verification/pipelineTb.sv
`timescale 1ns/1ps

module pipelineTb import pipelinePkg::*; ();

    localparam int outputIndexOffset = 8;
    localparam int outputLatency = 3;
    localparam int shiftDepth = (1 << indexWidth) - outputIndexOffset;
    localparam int clkPeriod = 8;

    // Generous cycle budgets per test, summed for the watchdog
    localparam int blankCycles = shiftDepth + 20;
    localparam int steadyCycles = 100 + 2 * shiftDepth;
    localparam int stallCycles = 4 * 200 + 2 * shiftDepth;
    localparam int swapCycles = 120 + 4 * shiftDepth;
    localparam int duplicateCycles = 100 + 4 * shiftDepth;
    localparam int initCycles = 3 * shiftDepth;
    localparam int watchdogCycles = blankCycles + steadyCycles + stallCycles + swapCycles
        + duplicateCycles + initCycles + 2000;

    logic                clk;
    logic                rst;
    logic                startNewTop;
    topT                 topIn;
    logic                isBotInValid;
    logic [topWidth-1:0] botIn;
    logic                pipelineReady;
    logic                readyForBotIn;
    logic                resultValid;
    resultT              result;

    integer seed = 47608;
    int     errorCount = 0;
    int     resultCount = 0;
    int     testCount = 0;
    int     failedTests = 0;
    int     testErrStart;
    int     testResStart;
    int     lowCycles;
    resultT expected [$];
    resultT want;
    resultT lastResult;

    // Behavioral model of the controller, index and drain rules
    ctrlStateT             modelState;
    topT                   modelTop;
    topT                   modelParked;
    logic [indexWidth-1:0] modelIndex;
    int                    modelDrain;
    logic                  modelAdvance;
    logic                  expectReady;
    logic                  swapNow;
    logic                  initEnd;

    pipelineTop #(
        .outputIndexOffset(outputIndexOffset),
        .outputLatency(outputLatency)
    ) uut (
        .clk(clk),
        .rst(rst),
        .startNewTop(startNewTop),
        .topIn(topIn),
        .isBotInValid(isBotInValid),
        .botIn(botIn),
        .pipelineReady(pipelineReady),
        .readyForBotIn(readyForBotIn),
        .resultValid(resultValid),
        .result(result)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Popcount of the bits set in both the top and the bot word
    function automatic logic [indexWidth-1:0] expectedScore(
        input topT                 topWord,
        input logic [topWidth-1:0] botWord
    );
        logic [topWidth-1:0]   shared;
        logic [indexWidth-1:0] total;
        shared = topWord & botWord;
        total = '0;
        for (int i = 0; i < topWidth; i++) begin
            if (shared[i]) begin
                total = total + indexWidth'(1);
            end
        end
        return total;
    endfunction

    function automatic logic readyDraw(input int stallPct);
        return ($unsigned($random(seed)) % 100) >= stallPct;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            // No bot may be taken while the pipeline is held in reset
            if (readyForBotIn !== 1'b0) begin
                $display("CHECK FAILED readyForBotIn expected %h got %h at %0t",
                    1'b0, readyForBotIn, $time);
                errorCount++;
            end
            modelState = running;
            modelTop = '0;
            modelParked = '0;
            modelIndex = '0;
            modelDrain = 0;
        end else begin
            modelAdvance = pipelineReady && (modelState != initializing);
            expectReady = modelAdvance && (modelState != topWaiting);
            swapNow = (modelState == topWaiting) && (modelDrain == 0);
            initEnd = pipelineReady && (modelIndex == '1);
            if (readyForBotIn !== expectReady) begin
                $display("CHECK FAILED readyForBotIn expected %h got %h at %0t",
                    expectReady, readyForBotIn, $time);
                errorCount++;
            end
            if (isBotInValid && readyForBotIn) begin
                expected.push_back('{score: expectedScore(modelTop, botIn), index: modelIndex});
            end
            if (modelAdvance) begin
                if (isBotInValid && readyForBotIn) begin
                    modelDrain = shiftDepth;
                end else if (modelDrain != 0) begin
                    modelDrain = modelDrain - 1;
                end
            end
            if (swapNow) begin
                modelIndex = indexWidth'(-outputIndexOffset);
            end else if (pipelineReady) begin
                modelIndex = modelIndex + indexWidth'(1);
            end
            case (modelState)
                running: begin
                    if (startNewTop) begin
                        modelParked = topIn;
                        modelState = topWaiting;
                    end
                end
                topWaiting: begin
                    // A second request while waiting is dropped
                    if (swapNow) begin
                        modelTop = modelParked;
                        modelState = initializing;
                    end
                end
                default: begin
                    if (startNewTop) begin
                        modelParked = topIn;
                        modelState = topWaiting;
                    end else if (initEnd) begin
                        modelState = running;
                    end
                end
            endcase
        end
    end

    // Results must come out in acceptance order
    always @(posedge clk) begin
        if (!rst && resultValid) begin
            resultCount++;
            lastResult = result;
            if (expected.size() == 0) begin
                $display("resultValid pulsed with no accepted bot left to report at %0t", $time);
                errorCount++;
            end else begin
                want = expected.pop_front();
                if (result.score !== want.score) begin
                    $display("CHECK FAILED result.score expected %h got %h", want.score,
                        result.score);
                    errorCount++;
                end
                if (result.index !== want.index) begin
                    $display("CHECK FAILED result.index expected %h got %h", want.index,
                        result.index);
                    errorCount++;
                end
            end
        end
    end

    task automatic pulseTop(input topT value);
        @(posedge clk);
        startNewTop <= 1'b1;
        topIn <= value;
        @(posedge clk);
        startNewTop <= 1'b0;
    endtask

    // Each bot word is held until the DUT takes it
    task automatic streamBots(input int count, input int stallPct);
        int taken;
        taken = 0;
        @(posedge clk);
        isBotInValid <= 1'b1;
        botIn <= $random(seed);
        pipelineReady <= readyDraw(stallPct);
        while (taken < count) begin
            @(posedge clk);
            if (isBotInValid && readyForBotIn) begin
                taken++;
                if (taken == count) begin
                    isBotInValid <= 1'b0;
                end else begin
                    botIn <= $random(seed);
                end
            end
            pipelineReady <= readyDraw(stallPct);
        end
        pipelineReady <= 1'b1;
    endtask

    task automatic drainResults();
        @(posedge clk);
        isBotInValid <= 1'b0;
        pipelineReady <= 1'b1;
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        repeat (outputLatency + 4) @(posedge clk);
    endtask

    task automatic beginTest();
        testErrStart = errorCount;
        testResStart = resultCount;
    endtask

    task automatic endTest(input string name, input int wantResults);
        drainResults();
        if (resultCount - testResStart != wantResults) begin
            $display("%s produced %0d results while %0d bots were accepted", name,
                resultCount - testResStart, wantResults);
            errorCount++;
        end
        testCount++;
        if (errorCount != testErrStart) begin
            failedTests++;
            $display("%s: FAIL with %0d errors", name, errorCount - testErrStart);
        end else begin
            $display("%s: PASS", name);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        startNewTop = 1'b0;
        topIn = '0;
        isBotInValid = 1'b0;
        botIn = '0;
        pipelineReady = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        beginTest();
        repeat (shiftDepth + outputLatency + 4) @(posedge clk);
        endTest("reset blanking", 0);

        beginTest();
        pulseTop(32'hF0F0_A5C3);
        do @(posedge clk); while (!readyForBotIn);
        streamBots(100, 0);
        endTest("steady stream", 100);

        beginTest();
        streamBots(200, 40);
        endTest("stalls", 200);

        beginTest();
        fork
            streamBots(120, 0);
            begin
                repeat (40) @(posedge clk);
                pulseTop(32'h0FF0_3C96);
            end
        join
        endTest("top swap mid-stream", 120);

        beginTest();
        fork
            streamBots(100, 0);
            begin
                repeat (30) @(posedge clk);
                pulseTop(32'hAAAA_5555);
                repeat (5) @(posedge clk);
                pulseTop(32'h1234_FEDC);
            end
        join
        endTest("ignored duplicate start", 100);

        // The bot is raised right after the request so it waits at the gate
        beginTest();
        @(posedge clk);
        startNewTop <= 1'b1;
        topIn <= 32'hC3C3_0FF1;
        @(posedge clk);
        startNewTop <= 1'b0;
        isBotInValid <= 1'b1;
        botIn <= 32'hFFFF_0001;
        lowCycles = 0;
        @(posedge clk);
        while (!readyForBotIn) begin
            lowCycles++;
            @(posedge clk);
        end
        isBotInValid <= 1'b0;
        if (lowCycles != 1 + outputIndexOffset) begin
            $display("CHECK FAILED readyForBotIn low cycles expected %h got %h",
                1 + outputIndexOffset, lowCycles);
            errorCount++;
        end
        drainResults();
        if (lastResult.index !== '0) begin
            $display("CHECK FAILED result.index expected %h got %h", 6'h00, lastResult.index);
            errorCount++;
        end
        endTest("initialization window", 1);

        $display("Tests run: %0d, tests failed: %0d, failed checks: %0d", testCount,
            failedTests, errorCount);
        if (failedTests == 0 && errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- source/pipelineTop.sv
`timescale 1ns/1ps

module pipelineTop import pipelinePkg::*; #(
    parameter int outputIndexOffset = 8,
    parameter int outputLatency = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                startNewTop,
    input  topT                 topIn,
    input  logic                isBotInValid,
    input  logic [topWidth-1:0] botIn,
    input  logic                pipelineReady,
    output logic                readyForBotIn,
    output logic                resultValid,
    output resultT              result
);

    logic                  advance;
    logic                  botAccepted;
    logic                  loadTop;
    logic                  allBotsCleared;
    logic                  initDone;
    logic [indexWidth-1:0] botIndex;
    topT                   top;
    botT                   indexedBot;

    assign indexedBot = '{word: botIn, index: botIndex};

    topLoadController controller (
        .clk(clk),
        .rst(rst),
        .startNewTop(startNewTop),
        .topIn(topIn),
        .isBotInValid(isBotInValid),
        .pipelineReady(pipelineReady),
        .allBotsCleared(allBotsCleared),
        .initDone(initDone),
        .advance(advance),
        .readyForBotIn(readyForBotIn),
        .botAccepted(botAccepted),
        .loadTop(loadTop),
        .top(top)
    );

    // The index must keep stepping through initialization, when advance is held low
    botIndexCounter #(.outputIndexOffset(outputIndexOffset)) indexCounter (
        .clk(clk),
        .rst(rst),
        .advance(pipelineReady),
        .loadTop(loadTop),
        .botIndex(botIndex),
        .initDone(initDone)
    );

    botValidTracker #(
        .outputIndexOffset(outputIndexOffset),
        .outputLatency(outputLatency)
    ) validTracker (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .botAccepted(botAccepted),
        .resultValid(resultValid),
        .allBotsCleared(allBotsCleared)
    );

    scorePipeline #(
        .outputIndexOffset(outputIndexOffset),
        .outputLatency(outputLatency)
    ) scorer (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .botAccepted(botAccepted),
        .top(top),
        .bot(indexedBot),
        .result(result)
    );

endmodule

//--- source/scorePipeline.sv
`timescale 1ns/1ps

module scorePipeline import pipelinePkg::*; #(
    parameter int outputIndexOffset = 8,
    parameter int outputLatency = 3
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   advance,
    input  logic   botAccepted,
    input  topT    top,
    input  botT    bot,
    output resultT result
);

    localparam int shiftDepth = (1 << indexWidth) - outputIndexOffset;

    resultT entry;
    resultT shifted;

    // Number of bit positions set in both words
    function automatic logic [indexWidth-1:0] sharedBits(
        input topT                 a,
        input logic [topWidth-1:0] b
    );
        logic [indexWidth-1:0] count;
        count = '0;
        for (int i = 0; i < topWidth; i++) begin
            count = count + indexWidth'(a[i] & b[i]);
        end
        return count;
    endfunction

    // Empty slots carry zero so that idle history stays clean
    always_comb begin
        entry = '0;
        if (botAccepted) begin
            entry.score = sharedBits(top, bot.word);
            entry.index = bot.index;
        end
    end

    // Same depth and enable as the valid history in botValidTracker
    enabledShiftRegister #(.cycles(shiftDepth), .width($bits(resultT))) scoreHistory (
        .clk(clk),
        .rst(rst),
        .enable(advance),
        .dataIn(entry),
        .dataOut(shifted)
    );

    // Same latency as the valid delay, so data lines up with resultValid
    delayPipe #(.cycles(outputLatency), .width($bits(resultT))) scoreDelay (
        .clk(clk),
        .rst(rst),
        .dataIn(shifted),
        .dataOut(result)
    );

endmodule

//--- source/topLoadController.sv
`timescale 1ns/1ps

module topLoadController import pipelinePkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                startNewTop,
    input  topT                 topIn,
    input  logic                isBotInValid,
    input  logic                pipelineReady,
    input  logic                allBotsCleared,
    input  logic                initDone,
    output logic                advance,
    output logic                readyForBotIn,
    output logic                botAccepted,
    output logic                loadTop,
    output topT                 top
);

    ctrlStateT state;
    topT       parkedTop;
    logic      parkTop;

    // The pipeline only moves when the consumer is ready and no
    // initialization window is open
    assign advance = pipelineReady && !rst && (state != initializing);
    assign readyForBotIn = advance && (state != topWaiting);
    assign botAccepted = isBotInValid && readyForBotIn;

    // A strobe that arrives while a top already waits is dropped
    assign parkTop = startNewTop && (state != topWaiting);

    // Swap once every bot in flight has left the shift history
    assign loadTop = (state == topWaiting) && allBotsCleared;

    always_ff @(posedge clk) begin
        if (parkTop) begin
            parkedTop <= topIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= running;
            top <= '0;
        end else begin
            case (state)
                running: begin
                    if (parkTop) begin
                        state <= topWaiting;
                    end
                end
                topWaiting: begin
                    if (loadTop) begin
                        top <= parkedTop;
                        state <= initializing;
                    end
                end
                initializing: begin
                    // A top requested during initialization restarts the swap
                    if (parkTop) begin
                        state <= topWaiting;
                    end else if (initDone) begin
                        state <= running;
                    end
                end
                default: state <= running;
            endcase
        end
    end

    // No bot may still be in flight while a new top initializes
    assert property (@(posedge clk) disable iff (rst)
        (state == initializing) |-> allBotsCleared)
        else $error("bots still in flight during initialization");

endmodule

//--- source/botIndexCounter.sv
`timescale 1ns/1ps

module botIndexCounter import pipelinePkg::*; #(
    parameter int outputIndexOffset = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic                  loadTop,
    output logic [indexWidth-1:0] botIndex,
    output logic                  initDone
);

    // Initialization ends on the step that wraps the index back to zero
    assign initDone = advance && (botIndex == '1);

    // The index wraps freely over the whole index space
    always_ff @(posedge clk) begin
        if (rst) begin
            botIndex <= '0;
        end else if (loadTop) begin
            // Starting below zero leaves outputIndexOffset steps of initialization
            botIndex <= indexWidth'(-outputIndexOffset);
        end else if (advance) begin
            botIndex <= botIndex + 1'b1;
        end
    end

endmodule

//--- source/botValidTracker.sv
`timescale 1ns/1ps

module botValidTracker import pipelinePkg::*; #(
    parameter int outputIndexOffset = 8,
    parameter int outputLatency = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic botAccepted,
    output logic resultValid,
    output logic allBotsCleared
);

    localparam int shiftDepth = (1 << indexWidth) - outputIndexOffset;

    logic [indexWidth-1:0] drainCount;
    logic [indexWidth-1:0] blankCount;
    logic                  blankDone;
    logic                  lastValid;
    logic                  prevAdvance;
    logic                  outputMark;

    assign allBotsCleared = drainCount == '0;
    assign blankDone = blankCount == '0;

    // The drain counter tracks how many advances the newest bot still needs
    // The blanking counter hides stale history right after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            drainCount <= '0;
            blankCount <= indexWidth'(shiftDepth);
            prevAdvance <= 1'b0;
        end else begin
            prevAdvance <= advance;
            if (advance) begin
                if (botAccepted) begin
                    drainCount <= indexWidth'(shiftDepth);
                end else if (!allBotsCleared) begin
                    drainCount <= drainCount - 1'b1;
                end
                if (!blankDone) begin
                    blankCount <= blankCount - 1'b1;
                end
            end
        end
    end

    enabledShiftRegister #(.cycles(shiftDepth), .width(1)) validHistory (
        .clk(clk),
        .rst(rst),
        .enable(advance),
        .dataIn(botAccepted),
        .dataOut(lastValid)
    );

    // The last entry stays put during a stall, so only the cycle right after
    // an advance may mark it, which keeps every result a single pulse
    assign outputMark = lastValid & blankDone & prevAdvance;

    delayPipe #(.cycles(outputLatency), .width(1)) validDelay (
        .clk(clk),
        .rst(rst),
        .dataIn(outputMark),
        .dataOut(resultValid)
    );

    // A cleared drain counter means no bot is left at the end of the history
    assert property (@(posedge clk) disable iff (rst)
        allBotsCleared |-> !lastValid)
        else $error("valid history holds a bot while reported cleared");

endmodule

//--- source/delayPipe.sv
`timescale 1ns/1ps

module delayPipe #(
    parameter int cycles = 3,
    parameter int width = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] dataIn,
    output logic [width-1:0] dataOut
);

    logic [width-1:0] stages [cycles];

    // Free running on purpose since stalls do not reach the output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cycles; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= dataIn;
            for (int i = 1; i < cycles; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dataOut = stages[cycles-1];

endmodule

//--- source/enabledShiftRegister.sv
`timescale 1ns/1ps

module enabledShiftRegister #(
    parameter int cycles = 4,
    parameter int width = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [width-1:0] dataIn,
    output logic [width-1:0] dataOut
);

    logic [width-1:0] stages [cycles];

    // The whole chain moves by one place per enable and holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cycles; i++) begin
                stages[i] <= '0;
            end
        end else if (enable) begin
            stages[0] <= dataIn;
            for (int i = 1; i < cycles; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dataOut = stages[cycles-1];

    // Unknown input taken on an enable would surface here many advances later
    assert property (@(posedge clk) disable iff (rst) !$isunknown(dataOut))
        else $error("enabledShiftRegister output went unknown");

endmodule

//--- source/pipelinePkg.sv
package pipelinePkg;

    // Width of the top word and of every bot word
    localparam int topWidth = 32;

    // Width of the bot index, so the index space holds 64 entries
    localparam int indexWidth = 6;

    typedef logic [topWidth-1:0] topT;

    // One bot word together with the index it was accepted under
    typedef struct packed {
        logic [topWidth-1:0]   word;
        logic [indexWidth-1:0] index;
    } botT;

    // The score counts shared set bits and needs to hold 0 to 32
    typedef struct packed {
        logic [indexWidth-1:0] score;
        logic [indexWidth-1:0] index;
    } resultT;

    // Controller states
    // A top waits in topWaiting until the shift history has drained
    typedef enum logic [1:0] {
        running,
        topWaiting,
        initializing
    } ctrlStateT;

endpackage
